// ==== hw/nibbleBurstPath.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibbleBurstPath (
    input  logic                     CLK,
    input  logic                     RST_N,
    sdramAccessIf.data               acc,
    input  logic                     beatRd,
    input  logic                     beatWr,
    input  logic [1:0]               beatIdx,
    output logic                     sdramDqm,
    inout  wire  [sdramPkg::DQ_W-1:0] sdramDq
);
    import sdramPkg::*;

    // two nibbles per byte select
    localparam int NIB_PER_SEL = BEATS / SEL_W;

    logic [WORD_W-1:0] rdWord;
    logic [DQ_W-1:0]   dqOut;
    logic              dqOe;

    // read gather
    // beat k lands in nibble k, low byte first
    always_ff @(posedge CLK) begin
        if (beatRd) begin
            rdWord[beatIdx*DQ_W +: DQ_W] <= sdramDq;
        end
    end

    assign acc.rdData = rdWord;

    // write nibble registered so it lines up with the command pins
    always_ff @(posedge CLK) begin
        dqOut <= acc.wrData[beatIdx*DQ_W +: DQ_W];
    end

    // drive enable and mask, one cycle per beat
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            dqOe     <= 1'b0;
            sdramDqm <= 1'b0;
        end else begin
            dqOe <= beatWr;
            // mask the nibbles of an unselected byte
            if (beatRd || beatWr) begin
                sdramDqm <= ~acc.sel[beatIdx / NIB_PER_SEL];
            end else begin
                sdramDqm <= 1'b0;
            end
        end
    end

    // bus released outside write beats
    assign sdramDq = dqOe ? dqOut : {DQ_W{1'bz}};

endmodule

`default_nettype wire

// ==== hw/sdramAccessIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// one latched access, shared by the bus port, sequencer and data path
interface sdramAccessIf;
    import sdramPkg::*;

    // request and address, held by the port until done
    logic              req;
    logic              we;
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;

    // byte selects and write word
    logic [SEL_W-1:0]  sel;
    logic [WORD_W-1:0] wrData;

    // single-cycle completion pulse
    logic              done;

    // gathered read word
    logic [WORD_W-1:0] rdData;

    modport port (
        output req, we, bank, row, col, sel, wrData,
        input  done, rdData
    );

    modport seq (
        input  req, we, bank, row, col,
        output done
    );

    modport data (
        input  sel, wrData,
        output rdData
    );

endinterface

`default_nettype wire

// ==== hw/sdramCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdramCtrlTop #(
    parameter int INIT_WAIT_CYCLES = 10000,
    parameter int REFRESH_INTERVAL = 1500
) (
    input  logic                             CLK,
    input  logic                             RST_N,
    input  logic                             locked,
    // wishbone classic slave
    input  logic                             wbCyc,
    input  logic                             wbStb,
    input  logic                             wbWe,
    input  logic [sdramPkg::WORD_ADR_W-1:0]   wbAdr,
    input  logic [sdramPkg::WORD_W-1:0]       wbDatW,
    input  logic [sdramPkg::SEL_W-1:0]        wbSel,
    output logic [sdramPkg::WORD_W-1:0]       wbDatR,
    output logic                             wbAck,
    // x4 sdram pins
    output logic                             sdramCke,
    output logic                             sdramCsN,
    output logic                             sdramRasN,
    output logic                             sdramCasN,
    output logic                             sdramWeN,
    output logic [sdramPkg::BANK_W-1:0]       sdramBa,
    output logic [sdramPkg::SDRAM_ADDR_W-1:0] sdramAddr,
    output logic                             sdramDqm,
    inout  wire  [sdramPkg::DQ_W-1:0]         sdramDq
);

    // beat strobes from sequencer to data path
    logic       beatRd;
    logic       beatWr;
    logic [1:0] beatIdx;

    sdramAccessIf acc ();

    wbSlavePort uPort (
        .CLK    (CLK),
        .RST_N  (RST_N),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbSel  (wbSel),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .acc    (acc.port)
    );

    sdramSequencer #(
        .INIT_WAIT_CYCLES (INIT_WAIT_CYCLES),
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) uSeq (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .locked    (locked),
        .acc       (acc.seq),
        .sdramCke  (sdramCke),
        .sdramCsN  (sdramCsN),
        .sdramRasN (sdramRasN),
        .sdramCasN (sdramCasN),
        .sdramWeN  (sdramWeN),
        .sdramBa   (sdramBa),
        .sdramAddr (sdramAddr),
        .beatRd    (beatRd),
        .beatWr    (beatWr),
        .beatIdx   (beatIdx)
    );

    nibbleBurstPath uData (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .acc      (acc.data),
        .beatRd   (beatRd),
        .beatWr   (beatWr),
        .beatIdx  (beatIdx),
        .sdramDqm (sdramDqm),
        .sdramDq  (sdramDq)
    );

endmodule

`default_nettype wire

// ==== hw/sdramPkg.sv ====
`default_nettype none

package sdramPkg;

    // command pins packed as {RAS_N, CAS_N, WE_N}, CS_N handled apart
    typedef enum logic [2:0] {
        CMD_LOAD_MODE = 3'b000,
        CMD_REFRESH   = 3'b001,
        CMD_PRECHARGE = 3'b010,
        CMD_ACTIVE    = 3'b011,
        CMD_WRITE     = 3'b100,
        CMD_READ      = 3'b101,
        CMD_NOP       = 3'b111
    } sdramCmdE;

    // power-up states first, then the access and refresh states
    typedef enum logic [4:0] {
        ST_WAIT_LOCK,
        ST_WAIT_POWER,
        ST_PRECHARGE_ALL,
        ST_INIT_REFRESH,
        ST_LOAD_MODE,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_RCD_WAIT,
        ST_READ_CMD,
        ST_WRITE_CMD,
        ST_CAS_WAIT,
        ST_BEAT,
        ST_RECOVER,
        // nop gap after each init command
        ST_INIT_GAP
    } seqStateE;

    // word address is {bank, row, col}
    localparam int BANK_W       = 2;
    localparam int ROW_W        = 10;
    localparam int COL_W        = 8;
    localparam int WORD_ADR_W   = BANK_W + ROW_W + COL_W;
    localparam int SDRAM_ADDR_W = 12;
    // auto-precharge / all-banks bit on the address pins
    localparam int AP_BIT       = 10;

    // x4 part, one word is four nibbles, low byte first
    localparam int DQ_W        = 4;
    localparam int WORD_W      = 16;
    localparam int SEL_W       = 2;
    localparam int BEATS       = 4;
    localparam int CAS_LATENCY = 2;

    // write burst programmed, standard op, CL2, sequential, BL4
    localparam logic [SDRAM_ADDR_W-1:0] MODE_WORD =
        {2'b00, 1'b0, 2'b00, 3'b010, 1'b0, 3'b010};

    // tRFC cover after every refresh
    localparam int GAP_CYCLES = 7;

endpackage

`default_nettype wire

// ==== hw/sdramSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdramSequencer #(
    parameter int INIT_WAIT_CYCLES = 10000,
    parameter int REFRESH_INTERVAL = 1500
) (
    input  logic                             CLK,
    input  logic                             RST_N,
    input  logic                             locked,
    sdramAccessIf.seq                        acc,
    output logic                             sdramCke,
    output logic                             sdramCsN,
    output logic                             sdramRasN,
    output logic                             sdramCasN,
    output logic                             sdramWeN,
    output logic [sdramPkg::BANK_W-1:0]       sdramBa,
    output logic [sdramPkg::SDRAM_ADDR_W-1:0] sdramAddr,
    output logic                             beatRd,
    output logic                             beatWr,
    output logic [1:0]                       beatIdx
);
    import sdramPkg::*;

    localparam int WAIT_W = $clog2(INIT_WAIT_CYCLES + 1);
    localparam int REF_W  = $clog2(REFRESH_INTERVAL + 1);
    localparam int STEP_W = $clog2(GAP_CYCLES + 1);

    seqStateE                state;
    // where the init gap goes next
    seqStateE                retState;
    logic                    initRefDone;
    logic [WAIT_W-1:0]       waitCnt;
    // shared step counter: gaps, cas wait, beats, recovery
    logic [STEP_W-1:0]       stepCnt;
    logic [REF_W-1:0]        refCnt;
    logic                    refPending;
    sdramCmdE                cmd;
    logic [SDRAM_ADDR_W-1:0] addrNext;
    logic [BANK_W-1:0]       baNext;

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            state       <= ST_WAIT_LOCK;
            retState    <= ST_INIT_REFRESH;
            initRefDone <= 1'b0;
            waitCnt     <= WAIT_W'(INIT_WAIT_CYCLES - 1);
            stepCnt     <= '0;
        end else begin
            case (state)
                ST_WAIT_LOCK: if (locked) state <= ST_WAIT_POWER;
                // long settling time before the first command
                ST_WAIT_POWER: begin
                    if (waitCnt == '0) begin
                        state <= ST_PRECHARGE_ALL;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                ST_PRECHARGE_ALL: begin
                    state    <= ST_INIT_GAP;
                    stepCnt  <= STEP_W'(GAP_CYCLES - 1);
                    retState <= ST_INIT_REFRESH;
                end
                // two refreshes, the flag tells the first from the second
                ST_INIT_REFRESH: begin
                    state       <= ST_INIT_GAP;
                    stepCnt     <= STEP_W'(GAP_CYCLES - 1);
                    initRefDone <= 1'b1;
                    retState    <= initRefDone ? ST_LOAD_MODE : ST_INIT_REFRESH;
                end
                ST_LOAD_MODE: begin
                    state    <= ST_INIT_GAP;
                    stepCnt  <= STEP_W'(GAP_CYCLES - 1);
                    retState <= ST_IDLE;
                end
                ST_INIT_GAP: begin
                    if (stepCnt == '0) begin
                        state <= retState;
                    end else begin
                        stepCnt <= stepCnt - 1'b1;
                    end
                end
                // pending refresh wins over a new access
                ST_IDLE: begin
                    if (refPending) begin
                        state   <= ST_REFRESH;
                        stepCnt <= STEP_W'(GAP_CYCLES);
                    end else if (acc.req) begin
                        state <= ST_ACTIVATE;
                    end
                end
                // refresh cycle plus GAP_CYCLES nops
                ST_REFRESH: begin
                    if (stepCnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        stepCnt <= stepCnt - 1'b1;
                    end
                end
                ST_ACTIVATE: state <= ST_RCD_WAIT;
                ST_RCD_WAIT: state <= acc.we ? ST_WRITE_CMD : ST_READ_CMD;
                ST_READ_CMD: begin
                    state   <= ST_CAS_WAIT;
                    stepCnt <= STEP_W'(CAS_LATENCY - 1);
                end
                // leaves with stepCnt at zero, which is beat 0
                ST_CAS_WAIT: begin
                    if (stepCnt == '0) begin
                        state <= ST_BEAT;
                    end else begin
                        stepCnt <= stepCnt - 1'b1;
                    end
                end
                // write cmd is beat 0, so beats continue at 1
                ST_WRITE_CMD: begin
                    state   <= ST_BEAT;
                    stepCnt <= STEP_W'(1);
                end
                ST_BEAT: begin
                    if (stepCnt == STEP_W'(BEATS - 1)) begin
                        state   <= ST_RECOVER;
                        stepCnt <= STEP_W'(1);
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                // two nops for auto-precharge to finish
                ST_RECOVER: begin
                    if (stepCnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        stepCnt <= stepCnt - 1'b1;
                    end
                end
                default: state <= ST_WAIT_LOCK;
            endcase
        end
    end

    // refresh timer, request stays up until a refresh goes out
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            refCnt     <= REF_W'(REFRESH_INTERVAL - 1);
            refPending <= 1'b0;
        end else if (cmd == CMD_REFRESH) begin
            refCnt     <= REF_W'(REFRESH_INTERVAL - 1);
            refPending <= 1'b0;
        end else if (refCnt == '0) begin
            refPending <= 1'b1;
        end else begin
            refCnt <= refCnt - 1'b1;
        end
    end

    // command and address from state
    always_comb begin
        cmd      = CMD_NOP;
        addrNext = '0;
        baNext   = '0;
        case (state)
            ST_PRECHARGE_ALL: begin
                // A10 high selects all banks
                cmd              = CMD_PRECHARGE;
                addrNext[AP_BIT] = 1'b1;
            end
            ST_INIT_REFRESH: cmd = CMD_REFRESH;
            ST_LOAD_MODE: begin
                cmd      = CMD_LOAD_MODE;
                addrNext = MODE_WORD;
            end
            ST_REFRESH: if (stepCnt == STEP_W'(GAP_CYCLES)) cmd = CMD_REFRESH;
            ST_ACTIVATE: begin
                cmd      = CMD_ACTIVE;
                addrNext = SDRAM_ADDR_W'(acc.row);
                baNext   = acc.bank;
            end
            ST_READ_CMD, ST_WRITE_CMD: begin
                cmd = (state == ST_READ_CMD) ? CMD_READ : CMD_WRITE;
                // word column to nibble column, burst starts at nibble 0
                addrNext[COL_W+1:0] = {acc.col, 2'b00};
                addrNext[AP_BIT]    = 1'b1;
                baNext              = acc.bank;
            end
            default: cmd = CMD_NOP;
        endcase
    end

    // pins registered, one cycle behind the state
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            sdramCke                           <= 1'b0;
            sdramCsN                           <= 1'b1;
            {sdramRasN, sdramCasN, sdramWeN}   <= CMD_NOP;
        end else begin
            // stays high once the clock has locked
            if (locked) sdramCke <= 1'b1;
            sdramCsN                           <= 1'b0;
            {sdramRasN, sdramCasN, sdramWeN}   <= cmd;
        end
    end

    always_ff @(posedge CLK) begin
        sdramAddr <= addrNext;
        sdramBa   <= baNext;
    end

    // beat strobes for the data path, read beats sample dq directly
    assign beatRd   = (state == ST_BEAT) && !acc.we;
    assign beatWr   = (state == ST_WRITE_CMD) || ((state == ST_BEAT) && acc.we);
    assign beatIdx  = (state == ST_BEAT) ? stepCnt[1:0] : 2'd0;
    assign acc.done = (state == ST_RECOVER) && (stepCnt == '0);

endmodule

`default_nettype wire

// ==== hw/wbSlavePort.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbSlavePort (
    input  logic                           CLK,
    input  logic                           RST_N,
    input  logic                           wbCyc,
    input  logic                           wbStb,
    input  logic                           wbWe,
    input  logic [sdramPkg::WORD_ADR_W-1:0] wbAdr,
    input  logic [sdramPkg::WORD_W-1:0]     wbDatW,
    input  logic [sdramPkg::SEL_W-1:0]      wbSel,
    output logic [sdramPkg::WORD_W-1:0]     wbDatR,
    output logic                           wbAck,
    sdramAccessIf.port                     acc
);
    import sdramPkg::*;

    logic capture;

    // new request only when nothing is held
    // the ack cycle is skipped too, the master still shows the old request then
    assign capture = wbCyc && wbStb && !acc.req && !wbAck;

    // req held from capture until the sequencer reports done
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            acc.req <= 1'b0;
            wbAck   <= 1'b0;
        end else begin
            // ack one cycle after done, lasts one cycle
            wbAck <= acc.done;
            if (capture) begin
                acc.req <= 1'b1;
            end else if (acc.done) begin
                acc.req <= 1'b0;
            end
        end
    end

    // access payload, frozen while req is high
    always_ff @(posedge CLK) begin
        if (capture) begin
            acc.we                         <= wbWe;
            {acc.bank, acc.row, acc.col}   <= wbAdr;
            acc.sel                        <= wbSel;
            acc.wrData                     <= wbDatW;
        end
    end

    // read word stays in the gather register until the next read,
    // so it is stable during ack
    assign wbDatR = acc.rdData;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and fail when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tbSdramCtrl -f verilog.f -o simTb \
    && ./obj_dir/simTb | tee sim.log \
    || { echo "build or run error"; exit 1; }
# an empty or missing log counts as a failure
test -s sim.log || { echo "no simulation log"; exit 1; }
grep -q "Checks failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0

// ==== sim/sdramModelX4.sv ====
`timescale 1ns/1ps
`default_nettype none

// x4 sdram with CL2 and burst 4, checks init order and bank use
module sdramModelX4 (
    input  logic        CLK,
    input  logic        cke,
    input  logic        csN,
    input  logic        rasN,
    input  logic        casN,
    input  logic        weN,
    input  logic [1:0]  ba,
    input  logic [11:0] addr,
    input  logic        dqm,
    inout  wire  [3:0]  dq
);
    // {RAS_N, CAS_N, WE_N} from the datasheet truth table
    localparam logic [2:0] LMR = 3'b000;
    localparam logic [2:0] REF = 3'b001;
    localparam logic [2:0] PRE = 3'b010;
    localparam logic [2:0] ACT = 3'b011;
    localparam logic [2:0] WR  = 3'b100;
    localparam logic [2:0] RD  = 3'b101;
    localparam logic [2:0] NOP = 3'b111;
    // programmed write burst, standard op, CL2, sequential, BL4
    localparam logic [11:0] EXPECTED_MODE = 12'h022;

    // nibble array keyed by {bank, row, nibble column}
    logic [3:0]  mem [logic [21:0]];
    logic [9:0]  openRow [4];
    logic [3:0]  bankOpen = 4'h0;
    logic [21:0] burstAdr = '0;
    logic [2:0]  wrLeft = 3'd0;
    logic [2:0]  rdLeft = 3'd0;
    logic [3:0]  dqOut = 4'h0;
    logic        dqOe = 1'b0;
    logic        precharged = 1'b0;
    logic        modeSet = 1'b0;
    int          initRefreshes = 0;
    int          refreshCount = 0;
    int          errCount = 0;
    logic [2:0]  cmd;

    assign cmd = {rasN, casN, weN};
    assign dq  = dqOe ? dqOut : 4'bzzzz;

    task automatic reportViolation(input string msg);
        errCount++;
        $display("sdram model at %0t ns: %s", $time, msg);
    endtask

    always @(posedge CLK) begin
        // write beats 1 to 3 follow the WRITE edge
        if (wrLeft != 3'd0) begin
            if (!dqm) mem[burstAdr] = dq;
            burstAdr[1:0] = burstAdr[1:0] + 2'd1;
            wrLeft        = wrLeft - 3'd1;
        end
        // CL2: nibble goes out after the edge following READ, valid one edge later
        if (rdLeft != 3'd0) begin
            dqOut         <= mem.exists(burstAdr) ? mem[burstAdr] : 4'h0;
            dqOe          <= 1'b1;
            burstAdr[1:0] = burstAdr[1:0] + 2'd1;
            rdLeft        = rdLeft - 3'd1;
        end else begin
            dqOe <= 1'b0;
        end
        if (cke && !csN && cmd != NOP) begin
            if (!precharged && !(cmd == PRE && addr[10])) begin
                reportViolation("command before precharge-all");
            end
            case (cmd)
                PRE: begin
                    if (addr[10]) begin
                        bankOpen   = 4'h0;
                        precharged = 1'b1;
                    end else begin
                        bankOpen[ba] = 1'b0;
                    end
                end
                REF: begin
                    refreshCount++;
                    if (!modeSet) initRefreshes++;
                    if (bankOpen != 4'h0) reportViolation("refresh with a bank open");
                end
                LMR: begin
                    if (initRefreshes < 2) begin
                        reportViolation("load-mode after fewer than two refreshes");
                    end
                    if (addr != EXPECTED_MODE) reportViolation("wrong mode register value");
                    modeSet = 1'b1;
                end
                ACT: begin
                    if (!modeSet) reportViolation("activate before load-mode");
                    if (bankOpen[ba]) reportViolation("activate on an open bank");
                    bankOpen[ba] = 1'b1;
                    openRow[ba]  = addr[9:0];
                end
                RD, WR: begin
                    if (!modeSet) reportViolation("read or write before load-mode");
                    if (!bankOpen[ba]) reportViolation("read or write on a closed bank");
                    burstAdr = {ba, openRow[ba], addr[9:0]};
                    if (cmd == WR) begin
                        // beat 0 comes with the command
                        if (!dqm) mem[burstAdr] = dq;
                        burstAdr[1:0] = burstAdr[1:0] + 2'd1;
                        wrLeft        = 3'd3;
                    end else begin
                        rdLeft = 3'd4;
                    end
                    // auto-precharge closes the bank behind the burst
                    if (addr[10]) bankOpen[ba] = 1'b0;
                end
                default: reportViolation("unsupported command");
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== sim/tbSdramCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbSdramCtrl;
    localparam int INIT_WAIT    = 200;
    localparam int REF_INTERVAL = 300;
    // lock, settling wait, then precharge, two refreshes and load-mode at 8 cycles each
    localparam int INIT_LEN     = INIT_WAIT + 4 * 8 + 10;
    // one refresh plus one access fits well inside this
    localparam int ENTRY_CYCLES = 40;
    localparam int ACK_LIMIT    = INIT_LEN + ENTRY_CYCLES;
    localparam int MAX_ENTRIES  = 48;

    logic        CLK;
    logic        RST_N;
    logic        locked;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [19:0] wbAdr;
    logic [15:0] wbDatW;
    logic [1:0]  wbSel;
    logic [15:0] wbDatR;
    logic        wbAck;
    logic        sdramCke;
    logic        sdramCsN;
    logic        sdramRasN;
    logic        sdramCasN;
    logic        sdramWeN;
    logic [1:0]  sdramBa;
    logic [11:0] sdramAddr;
    logic        sdramDqm;
    wire  [3:0]  sdramDq;

    // stimulus table, one row per bus access
    string       tName   [MAX_ENTRIES];
    logic        tWrite  [MAX_ENTRIES];
    logic [19:0] tAdr    [MAX_ENTRIES];
    logic [15:0] tData   [MAX_ENTRIES];
    logic [1:0]  tSel    [MAX_ENTRIES];
    logic [15:0] tExpect [MAX_ENTRIES];
    int          tIdle   [MAX_ENTRIES];
    int          nEntries;
    // expected memory contents, unwritten words read as zero
    logic [15:0] shadow [logic [19:0]];
    integer      seed;
    int          passCount;
    int          failCount;
    logic        tableReady = 1'b0;

    sdramCtrlTop #(
        .INIT_WAIT_CYCLES (INIT_WAIT),
        .REFRESH_INTERVAL (REF_INTERVAL)
    ) UUT (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .locked    (locked),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbSel     (wbSel),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .sdramCke  (sdramCke),
        .sdramCsN  (sdramCsN),
        .sdramRasN (sdramRasN),
        .sdramCasN (sdramCasN),
        .sdramWeN  (sdramWeN),
        .sdramBa   (sdramBa),
        .sdramAddr (sdramAddr),
        .sdramDqm  (sdramDqm),
        .sdramDq   (sdramDq)
    );

    sdramModelX4 sdram (
        .CLK  (CLK),
        .cke  (sdramCke),
        .csN  (sdramCsN),
        .rasN (sdramRasN),
        .casN (sdramCasN),
        .weN  (sdramWeN),
        .ba   (sdramBa),
        .addr (sdramAddr),
        .dqm  (sdramDqm),
        .dq   (sdramDq)
    );

    // 40 ns period
    always #20 CLK = ~CLK;

    function automatic logic [19:0] wordAdr(input logic [1:0] bank, input logic [9:0] row,
                                            input logic [7:0] col);
        return {bank, row, col};
    endfunction

    task automatic appendEntry(input string name, input logic isWrite, input logic [19:0] adr,
                               input logic [15:0] data, input logic [1:0] sel,
                               input logic [15:0] expVal, input int idle);
        tName[nEntries]   = name;
        tWrite[nEntries]  = isWrite;
        tAdr[nEntries]    = adr;
        tData[nEntries]   = data;
        tSel[nEntries]    = sel;
        tExpect[nEntries] = expVal;
        tIdle[nEntries]   = idle;
        nEntries++;
    endtask

    task automatic addWrite(input string name, input logic [19:0] adr, input logic [15:0] data,
                            input logic [1:0] sel, input int idle);
        logic [15:0] old;
        old = shadow.exists(adr) ? shadow[adr] : 16'h0000;
        // selected bytes take the new data, the others keep the old word
        shadow[adr] = {sel[1] ? data[15:8] : old[15:8], sel[0] ? data[7:0] : old[7:0]};
        appendEntry(name, 1'b1, adr, data, sel, 16'h0000, idle);
    endtask

    task automatic addRead(input string name, input logic [19:0] adr, input int idle);
        logic [15:0] expVal;
        expVal = shadow.exists(adr) ? shadow[adr] : 16'h0000;
        appendEntry(name, 1'b0, adr, 16'h0000, 2'b11, expVal, idle);
    endtask

    task automatic buildTable();
        logic [19:0] pool [4];
        logic [19:0] rtAdr;
        logic [19:0] bmAdr;
        logic [19:0] refAdr;
        logic [1:0]  pick;
        rtAdr  = wordAdr(2'd0, 10'h012, 8'h34);
        bmAdr  = wordAdr(2'd1, 10'h040, 8'h10);
        refAdr = wordAdr(2'd2, 10'h2A5, 8'hC7);
        addWrite("rt_w", rtAdr, 16'hA5C3, 2'b11, 0);
        addRead("rt_r", rtAdr, 2);
        // full word, then low byte only, then high byte only
        addWrite("bm_full_w", bmAdr, 16'hA1B2, 2'b11, 0);
        addRead("bm_full_r", bmAdr, 0);
        addWrite("bm_lo_w", bmAdr, 16'h1177, 2'b01, 1);
        addRead("bm_lo_r", bmAdr, 0);
        addWrite("bm_hi_w", bmAdr, 16'h88EE, 2'b10, 0);
        addRead("bm_hi_r", bmAdr, 3);
        // same column in every bank, rows differ too
        addWrite("ad_w_b0", wordAdr(2'd0, 10'h003, 8'h55), 16'h0B00, 2'b11, 0);
        addWrite("ad_w_b1", wordAdr(2'd1, 10'h003, 8'h55), 16'h1B11, 2'b11, 0);
        addWrite("ad_w_b2", wordAdr(2'd2, 10'h009, 8'h55), 16'h2B22, 2'b11, 0);
        addWrite("ad_w_b3", wordAdr(2'd3, 10'h3FF, 8'h55), 16'h3B33, 2'b11, 0);
        addRead("ad_r_b0", wordAdr(2'd0, 10'h003, 8'h55), 0);
        addRead("ad_r_b1", wordAdr(2'd1, 10'h003, 8'h55), 0);
        addRead("ad_r_b2", wordAdr(2'd2, 10'h009, 8'h55), 0);
        addRead("ad_r_b3", wordAdr(2'd3, 10'h3FF, 8'h55), 0);
        // long idle gaps, data has to survive them
        addWrite("ref_w", refAdr, 16'h5EED, 2'b11, 0);
        addRead("ref_r", refAdr, 800);
        addRead("ref_rt_r", rtAdr, 650);
        // small pool so random accesses hit the same words
        for (int k = 0; k < 4; k++) begin
            pool[k] = 20'($random(seed));
        end
        for (int k = 0; k < 12; k++) begin
            pick = 2'($random(seed));
            addWrite($sformatf("rnd_w%0d", k), pool[pick], 16'($random(seed)),
                     2'($random(seed)), int'(2'($random(seed))));
            addRead($sformatf("rnd_r%0d", k), pool[pick], 0);
        end
    endtask

    // one wishbone classic cycle, driven and sampled on the falling edge
    task automatic runAccess(input int i);
        int waited;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = tWrite[i];
        wbAdr  = tAdr[i];
        wbDatW = tData[i];
        wbSel  = tSel[i];
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (!wbAck && waited < ACK_LIMIT);
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        if (!wbAck) begin
            failCount++;
            $display("%s got no acknowledge within %0d cycles", tName[i], ACK_LIMIT);
        end else if (!tWrite[i]) begin
            if (wbDatR !== tExpect[i]) begin
                failCount++;
                $display("FAIL %s expected %h actual %h", tName[i], tExpect[i], wbDatR);
            end else begin
                passCount++;
                $display("PASS %s read %h", tName[i], wbDatR);
            end
        end
    endtask

    task automatic checkRefresh(input string name, input int idle, input int refStart);
        int grown;
        int need;
        grown = sdram.refreshCount - refStart;
        need  = idle / REF_INTERVAL - 1;
        if (grown < need) begin
            failCount++;
            $display("FAIL refresh_before_%s expected >=%0d actual %0d", name, need, grown);
        end else begin
            passCount++;
            $display("PASS refresh_before_%s count %0d", name, grown);
        end
    endtask

    task automatic checkProtocol();
        if (!sdram.modeSet) begin
            failCount++;
            $display("the SDRAM never received a load-mode command");
        end else if (sdram.errCount != 0) begin
            failCount++;
            $display("the SDRAM model reported %0d protocol errors", sdram.errCount);
        end else begin
            passCount++;
            $display("PASS init order and bank protocol");
        end
    endtask

    initial begin
        int refBefore;
        CLK       = 1'b0;
        RST_N     = 1'b0;
        locked    = 1'b0;
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbAdr     = '0;
        wbDatW    = '0;
        wbSel     = '0;
        seed      = 44662;
        passCount = 0;
        failCount = 0;
        nEntries  = 0;
        buildTable();
        tableReady = 1'b1;
        // reset held over five rising edges, lock two cycles later
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RST_N = 1'b1;
        repeat (2) @(negedge CLK);
        locked = 1'b1;
        for (int i = 0; i < nEntries; i++) begin
            refBefore = sdram.refreshCount;
            repeat (tIdle[i]) @(negedge CLK);
            if (tIdle[i] >= REF_INTERVAL) checkRefresh(tName[i], tIdle[i], refBefore);
            runAccess(i);
        end
        checkProtocol();
        $display("checks run %0d, passed %0d, failed %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin : watchdog
        int limit;
        wait (tableReady);
        limit = INIT_LEN + ENTRY_CYCLES * nEntries;
        for (int i = 0; i < nEntries; i++) begin
            limit += tIdle[i];
        end
        limit = limit * 2;
        repeat (limit) @(posedge CLK);
        $display("watchdog expired after %0d cycles, run stopped", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/sdramPkg.sv
hw/sdramAccessIf.sv
hw/wbSlavePort.sv
hw/sdramSequencer.sv
hw/nibbleBurstPath.sv
hw/sdramCtrlTop.sv
sim/sdramModelX4.sv
sim/tbSdramCtrl.sv
